// File: compile.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/decode_ctrl_pkg.sv
rtl/imm_gen.sv
rtl/base_decoder.sv
rtl/muldiv_decoder.sv
rtl/decode_stage_reg.sv
rtl/inst_decoder.sv
dv/inst_decoder_properties.sv
dv/inst_decoder_tb.sv

// File: dv/inst_decoder_properties.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder_properties
	import decode_ctrl_pkg::*;
(
	input logic         clk,
	input logic         rst_n,
	input logic         id_valid,
	input decode_ctrl_t id_ctrl
);

	logic any_access;                                    // Some register port is used
	logic any_jump;                                      // Some jump flag is raised

	assign any_access = id_ctrl.rs1_access | id_ctrl.rs2_access | id_ctrl.rd_access;
	assign any_jump   = id_ctrl.jump_ena | id_ctrl.jump_ind | id_ctrl.jump_alw;

	// The strobe must stay low for as long as reset is held
	reset_idle: assert property (@(posedge clk) !rst_n |-> !id_valid)
		else $error("id_valid is high while rst_n is low");

	illegal_idle: assert property (@(posedge clk) disable iff (!rst_n)
		id_ctrl.illegal_inst |-> !any_access && !any_jump)
		else $error("Illegal word carries access or jump flags");

	indirect_always: assert property (@(posedge clk) disable iff (!rst_n)
		id_ctrl.jump_ind |-> id_ctrl.jump_alw)
		else $error("Indirect jump without the unconditional flag");

	muldiv_writes: assert property (@(posedge clk) disable iff (!rst_n)
		(id_ctrl.wb_src == WB_MUL || id_ctrl.wb_src == WB_DIV) |-> id_ctrl.rd_access)
		else $error("Multiply or divide result without an rd write");

endmodule

bind inst_decoder inst_decoder_properties u_properties (
	.clk      (clk),
	.rst_n    (rst_n),
	.id_valid (id_valid),
	.id_ctrl  (id_ctrl)
);

`default_nettype wire

// File: dv/inst_decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module inst_decoder_tb
	import rv_isa_pkg::*;
	import decode_ctrl_pkg::*;
();

	localparam int RESET_CYCLES = 10;
	localparam int N_DIRECTED   = 96;                    // 48 encodings each taken with both signs
	localparam int N_LEGAL      = 2000;
	localparam int N_RAW        = 1000;
	localparam int N_GAP        = 300;
	localparam int CYCLE_LIMIT  = 2 * RESET_CYCLES + N_DIRECTED + N_LEGAL + N_RAW + N_GAP + 200;

	logic         clk;
	logic         rst_n;
	word_t        ir;
	logic         ir_valid;
	logic         id_valid;
	decode_ctrl_t id_ctrl;
	word_t        id_imm;

	logic         exp_valid_q[$];                        // One entry per driven cycle
	decode_ctrl_t exp_ctrl_q[$];
	word_t        exp_imm_q[$];
	word_t        exp_ir_q[$];                           // Source word for error lines
	decode_ctrl_t held_ctrl;                             // Model of the output register
	word_t        held_imm;
	int           errors;
	int           checks;
	int           test_errors;
	int           test_vectors;
	int           cycle_count;

	inst_decoder u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.ir       (ir),
		.ir_valid (ir_valid),
		.id_valid (id_valid),
		.id_ctrl  (id_ctrl),
		.id_imm   (id_imm)
	);

	always #20 clk = ~clk;                               // 40 ns period

	task automatic check_ctrl(input decode_ctrl_t got, input decode_ctrl_t exp, input word_t w);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("error %0t: control word for ir %h is %h, expected %h", $time, w, got, exp);
		end
	endtask

	task automatic check_imm(input word_t got, input word_t exp, input word_t w);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("error %0t: immediate for ir %h is %h, expected %h", $time, w, got, exp);
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("error %0t: id_valid is %b, expected %b", $time, got, exp);
		end
	endtask

	function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd,
		input logic [`OPCODE_W-1:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic word_t i_type(input logic [11:0] i, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd, input logic [`OPCODE_W-1:0] op);
		return {i, rs1, f3, rd, op};
	endfunction

	function automatic word_t s_type(input logic [11:0] i, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {i[11:5], rs2, rs1, f3, i[4:0], 7'b0100011};
	endfunction

	function automatic word_t b_type(input logic [12:0] i, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {i[12], i[10:5], rs2, rs1, f3, i[4:1], i[11], 7'b1100011};
	endfunction

	function automatic word_t j_type(input logic [20:0] i, input reg_addr_t rd);
		return {i[20], i[10:1], i[11], i[19:12], rd, 7'b1101111};
	endfunction

	// Encodings 0 to 39 follow the RV32I table in order and 40 to 47 are RV32M
	function automatic word_t legal_word(input int k, input logic sgn);
		word_t       r1;
		word_t       r2;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		reg_addr_t   rd;
		logic [4:0]  shamt;
		logic [11:0] i12;
		logic [12:0] i13;
		logic [20:0] i21;
		logic [19:0] u20;
		r1    = $urandom;
		r2    = $urandom;
		rs1   = r1[4:0];
		rs2   = r1[9:5];
		rd    = r1[14:10];
		shamt = r1[19:15];
		i12   = {sgn, r2[10:0]};                         // Sign bit forced by the caller
		i13   = {sgn, r2[10:0], 1'b0};
		i21   = {sgn, r2[18:0], 1'b0};
		u20   = {sgn, r2[18:0]};
		if (k == 0) return {u20, rd, OPC_LUI};
		if (k == 1) return {u20, rd, OPC_AUIPC};
		if (k == 2) return j_type(i21, rd);
		if (k == 3) return i_type(i12, rs1, 3'd0, rd, OPC_JALR);
		if (k <= 9) return b_type(i13, rs2, rs1, 3'(k < 6 ? k - 4 : k - 2));
		if (k <= 14) return i_type(i12, rs1, 3'(k < 13 ? k - 10 : k - 9), rd, OPC_LOAD);
		if (k <= 17) return s_type(i12, rs2, rs1, 3'(k - 15));
		if (k <= 23) return i_type(i12, rs1, 3'(k == 18 ? 0 : (k < 22 ? k - 17 : k - 16)),
			rd, OPC_OP_IMM);
		if (k == 24) return i_type({7'h00, shamt}, rs1, 3'd1, rd, OPC_OP_IMM);
		if (k == 25) return i_type({7'h00, shamt}, rs1, 3'd5, rd, OPC_OP_IMM);
		if (k == 26) return i_type({7'h20, shamt}, rs1, 3'd5, rd, OPC_OP_IMM);
		if (k <= 34) return r_type(7'h00, rs2, rs1, 3'(k - 27), rd, OPC_OP);
		if (k == 35) return r_type(7'h20, rs2, rs1, 3'd0, rd, OPC_OP);    // SUB
		if (k == 36) return r_type(7'h20, rs2, rs1, 3'd5, rd, OPC_OP);    // SRA
		if (k == 37) return i_type(i12, rs1, 3'd0, rd, OPC_MISC_MEM);     // FENCE
		if (k == 38) return 32'h0000_0073;
		if (k == 39) return 32'h0010_0073;
		return r_type(7'h01, rs2, rs1, 3'(k - 40), rd, OPC_OP);
	endfunction

	function automatic alu_op_e alu_for_f3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? ALU_SUB : ALU_ADD;
			3'd1:    return ALU_SLL;
			3'd2:    return ALU_SLT;
			3'd3:    return ALU_SLTU;
			3'd4:    return ALU_XOR;
			3'd5:    return alt ? ALU_SRA : ALU_SRL;
			3'd6:    return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// Reference decode straight from the RV32I and RV32M encoding tables
	function automatic decode_ctrl_t expect_ctrl(input word_t w);
		decode_ctrl_t c;
		logic [2:0]   f3;
		logic [6:0]   f7;
		logic         ok;
		f3 = w[14:12];
		f7 = w[31:25];
		c  = '0;
		ok = 1'b1;
		case (w[6:0])
			7'b0110111, 7'b0010111: begin                // LUI and AUIPC
				c.rd_access = 1'b1;
				c.sel_im    = 1'b1;
				c.sel_pc    = (w[6:0] == 7'b0010111);
			end
			7'b1101111, 7'b1100111: begin                // JAL and JALR
				ok           = (w[6:0] == 7'b1101111) || (f3 == 3'd0);
				c.rs1_access = (w[6:0] == 7'b1100111);
				c.rd_access  = 1'b1;
				c.sel_pc     = 1'b1;
				c.alu_op     = ALU_INC;
				c.jump_ena   = 1'b1;
				c.jump_ind   = (w[6:0] == 7'b1100111);
				c.jump_alw   = 1'b1;
			end
			7'b1100011: begin
				c.rs1_access = 1'b1;
				c.rs2_access = 1'b1;
				c.jump_ena   = 1'b1;
				case (f3)
					3'd0:    c.alu_op = ALU_SEQ;
					3'd1:    c.alu_op = ALU_SNE;
					3'd4:    c.alu_op = ALU_SLT;
					3'd5:    c.alu_op = ALU_SGE;
					3'd6:    c.alu_op = ALU_SLTU;
					3'd7:    c.alu_op = ALU_SGEU;
					default: ok = 1'b0;
				endcase
			end
			7'b0000011, 7'b0100011: begin                // Loads and stores
				c.rs1_access = 1'b1;
				c.rs2_access = w[5];
				c.rd_access  = !w[5];
				c.sel_im     = 1'b1;
				c.wb_src     = WB_MEM;
				case ({w[5], f3})
					4'b0000: c.mem_op = MEM_LB;
					4'b0001: c.mem_op = MEM_LH;
					4'b0010: c.mem_op = MEM_LW;
					4'b0100: c.mem_op = MEM_LBU;
					4'b0101: c.mem_op = MEM_LHU;
					4'b1000: c.mem_op = MEM_SB;
					4'b1001: c.mem_op = MEM_SH;
					4'b1010: c.mem_op = MEM_SW;
					default: ok = 1'b0;
				endcase
			end
			7'b0010011: begin
				c.rs1_access = 1'b1;
				c.rd_access  = 1'b1;
				c.sel_im     = 1'b1;
				c.alu_op     = alu_for_f3(f3, (f3 == 3'd5) && (f7 == 7'h20));
				if (f3 == 3'd1) ok = (f7 == 7'h00);
				if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
			end
			7'b0110011: begin
				c.rs1_access = 1'b1;
				c.rs2_access = 1'b1;
				c.rd_access  = 1'b1;
				if (f7 == 7'h01) begin
					c.wb_src = f3[2] ? WB_DIV : WB_MUL;
					case (f3)
						3'd1:    c.mul_op = SMULH;
						3'd2:    c.mul_op = SUMULH;
						3'd3:    c.mul_op = UMULH;
						3'd5:    c.div_op = UDIV;
						3'd6:    c.div_op = SREM;
						3'd7:    c.div_op = UREM;
						default: c.mul_op = UMULL;          // MUL and DIV both use code zero
					endcase
				end else begin
					ok       = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
					c.alu_op = alu_for_f3(f3, f7 == 7'h20);
				end
			end
			7'b0001111: ok = (f3 == 3'd0);
			7'b1110011: ok = (w == 32'h0000_0073) || (w == 32'h0010_0073);
			default:    ok = 1'b0;
		endcase
		if (!ok) begin
			c              = '0;
			c.illegal_inst = 1'b1;
		end
		c.rs1_addr = w[19:15];
		c.rs2_addr = w[24:20];
		c.rd_addr  = w[11:7];
		return c;
	endfunction

	function automatic word_t expect_imm(input word_t w);
		decode_ctrl_t c;
		c = expect_ctrl(w);
		if (c.illegal_inst) return '0;
		case (w[6:0])
			7'b0110111, 7'b0010111:             return {w[31:12], 12'h000};
			7'b1101111:                         return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			7'b1100111, 7'b0000011, 7'b0010011: return {{21{w[31]}}, w[30:20]};
			7'b0100011:                         return {{21{w[31]}}, w[30:25], w[11:7]};
			7'b1100011:                         return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			default:                            return '0;
		endcase
	endfunction

	// Checks the word captured at this edge and then drives the next one
	task automatic step(input word_t w, input logic v);
		word_t ew;
		@(posedge clk);
		#1;
		if (exp_valid_q.size() > 0) begin
			ew = exp_ir_q.pop_front();
			check_valid(id_valid, exp_valid_q.pop_front());
			check_ctrl(id_ctrl, exp_ctrl_q.pop_front(), ew);
			check_imm(id_imm, exp_imm_q.pop_front(), ew);
		end
		ir       = w;
		ir_valid = v;
		if (v) begin
			held_ctrl = expect_ctrl(w);
			held_imm  = expect_imm(w);
		end
		exp_valid_q.push_back(v);
		exp_ctrl_q.push_back(held_ctrl);                 // A gap repeats the held values
		exp_imm_q.push_back(held_imm);
		exp_ir_q.push_back(w);
		test_vectors++;
	endtask

	task automatic apply_reset();
		word_t r;
		rst_n = 1'b0;                                    // The asynchronous reset clears the outputs at once
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			#1;
			check_valid(id_valid, 1'b0);
			check_ctrl(id_ctrl, '0, ir);
			check_imm(id_imm, '0, ir);
			r        = $urandom;
			ir       = $urandom;
			ir_valid = r[0];                             // Strobes in reset must not get through
		end
		rst_n     = 1'b1;
		ir_valid  = 1'b0;
		held_ctrl = '0;
		held_imm  = '0;
		exp_valid_q.delete();
		exp_ctrl_q.delete();
		exp_imm_q.delete();
		exp_ir_q.delete();
		exp_valid_q.push_back(1'b0);
		exp_ctrl_q.push_back('0);
		exp_imm_q.push_back('0);
		exp_ir_q.push_back(ir);
	endtask

	task automatic finish_test(input string name);
		step(ir, 1'b0);                                  // Drains the last valid word
		$display("test %s: %0d vectors, %0d errors", name, test_vectors, test_errors);
		test_vectors = 0;
		test_errors  = 0;
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		word_t r;
		clk          = 1'b0;
		rst_n        = 1'b0;
		ir           = '0;
		ir_valid     = 1'b0;
		errors       = 0;
		checks       = 0;
		test_errors  = 0;
		test_vectors = 0;
		held_ctrl    = '0;
		held_imm     = '0;
		void'($urandom(32'h2512_d81f));
		apply_reset();
		for (int k = 0; k < 40; k++) begin
			step(legal_word(k, 1'b0), 1'b1);
			step(legal_word(k, 1'b1), 1'b1);         // Negative immediates and offsets
		end
		finish_test("rv32i_directed");
		for (int k = 40; k < 48; k++) begin
			step(legal_word(k, 1'b0), 1'b1);
			step(legal_word(k, 1'b1), 1'b1);
		end
		finish_test("rv32m_directed");
		for (int n = 0; n < N_LEGAL; n++) begin
			r = $urandom;
			step(legal_word(int'($urandom_range(47, 0)), r[0]), 1'b1);
		end
		finish_test("random_legal");
		for (int n = 0; n < N_RAW; n++) begin
			step($urandom, 1'b1);
		end
		finish_test("random_raw");
		for (int n = 0; n < N_GAP; n++) begin
			r = $urandom;
			if (n == N_GAP / 2) apply_reset();           // Reset again in the middle of traffic
			step(r[2] ? legal_word(int'($urandom_range(47, 0)), r[3]) : $urandom,
				r[1:0] != 2'b00);
		end
		finish_test("strobe_and_reset");
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/base_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module base_decoder
	import rv_isa_pkg::*;
	import decode_ctrl_pkg::*;
(
	input  word_t        ir,
	output logic         base_hit,
	output decode_ctrl_t base_ctrl,
	output imm_fmt_e     imm_fmt
);

	inst_fields_t f;
	logic         f7_base;                               // Upper bits are all zero
	logic         f7_alt;                                // Upper bits select SUB or SRA

	assign f       = inst_fields_t'(ir);
	assign f7_base = (f.funct7 == F7_BASE);
	assign f7_alt  = (f.funct7 == F7_ALT);

	always_comb begin
		base_ctrl = CTRL_NOP;
		base_hit  = 1'b0;
		imm_fmt   = IMM_NONE;
		case (f.opcode)
			OPC_LUI, OPC_AUIPC: begin
				base_hit           = 1'b1;
				imm_fmt            = IMM_U;
				base_ctrl.rd_access = 1'b1;
				base_ctrl.sel_im   = 1'b1;               // Result is zero or PC plus the immediate
				base_ctrl.sel_pc   = (f.opcode == OPC_AUIPC);
				base_ctrl.alu_op   = ALU_ADD;
			end
			OPC_JAL, OPC_JALR: begin
				base_hit             = (f.opcode == OPC_JAL) || (f.funct3 == 3'd0);
				imm_fmt              = (f.opcode == OPC_JAL) ? IMM_J : IMM_I;
				base_ctrl.rs1_access = (f.opcode == OPC_JALR); // Only JALR has a register base
				base_ctrl.rd_access  = 1'b1;
				base_ctrl.sel_pc     = 1'b1;             // The ALU forms the link address
				base_ctrl.alu_op     = ALU_INC;
				base_ctrl.jump_ena   = 1'b1;
				base_ctrl.jump_ind   = (f.opcode == OPC_JALR);
				base_ctrl.jump_alw   = 1'b1;
			end
			OPC_BRANCH: begin
				base_hit             = 1'b1;
				imm_fmt              = IMM_B;
				base_ctrl.rs1_access = 1'b1;
				base_ctrl.rs2_access = 1'b1;
				base_ctrl.jump_ena   = 1'b1;             // The ALU compare decides the jump
				case (f.funct3)
					F3_BEQ:  base_ctrl.alu_op = ALU_SEQ;
					F3_BNE:  base_ctrl.alu_op = ALU_SNE;
					F3_BLT:  base_ctrl.alu_op = ALU_SLT;
					F3_BGE:  base_ctrl.alu_op = ALU_SGE;
					F3_BLTU: base_ctrl.alu_op = ALU_SLTU;
					F3_BGEU: base_ctrl.alu_op = ALU_SGEU;
					default: base_hit = 1'b0;            // Codes 2 and 3 are reserved
				endcase
			end
			OPC_LOAD: begin
				base_hit             = 1'b1;
				imm_fmt              = IMM_I;
				base_ctrl.rs1_access = 1'b1;
				base_ctrl.rd_access  = 1'b1;
				base_ctrl.sel_im     = 1'b1;             // Address is rs1 plus the offset
				base_ctrl.wb_src     = WB_MEM;
				base_ctrl.alu_op     = ALU_ADD;
				case (f.funct3)
					F3_B:    base_ctrl.mem_op = MEM_LB;
					F3_H:    base_ctrl.mem_op = MEM_LH;
					F3_W:    base_ctrl.mem_op = MEM_LW;
					F3_BU:   base_ctrl.mem_op = MEM_LBU;
					F3_HU:   base_ctrl.mem_op = MEM_LHU;
					default: base_hit = 1'b0;
				endcase
			end
			OPC_STORE: begin
				base_hit             = 1'b1;
				imm_fmt              = IMM_S;
				base_ctrl.rs1_access = 1'b1;
				base_ctrl.rs2_access = 1'b1;             // Store data comes from rs2
				base_ctrl.sel_im     = 1'b1;
				base_ctrl.wb_src     = WB_MEM;
				base_ctrl.alu_op     = ALU_ADD;
				case (f.funct3)
					F3_B:    base_ctrl.mem_op = MEM_SB;
					F3_H:    base_ctrl.mem_op = MEM_SH;
					F3_W:    base_ctrl.mem_op = MEM_SW;
					default: base_hit = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				base_hit             = 1'b1;
				imm_fmt              = IMM_I;            // Shift amounts sit in the low imm bits
				base_ctrl.rs1_access = 1'b1;
				base_ctrl.rd_access  = 1'b1;
				base_ctrl.sel_im     = 1'b1;
				case (f.funct3)
					F3_ADD_SUB: base_ctrl.alu_op = ALU_ADD;
					F3_SLT:     base_ctrl.alu_op = ALU_SLT;
					F3_SLTU:    base_ctrl.alu_op = ALU_SLTU;
					F3_XOR:     base_ctrl.alu_op = ALU_XOR;
					F3_OR:      base_ctrl.alu_op = ALU_OR;
					F3_AND:     base_ctrl.alu_op = ALU_AND;
					F3_SLL: begin
						base_hit         = f7_base;      // SLLI has no alternate form
						base_ctrl.alu_op = ALU_SLL;
					end
					F3_SRL_SRA: begin
						base_hit         = f7_base || f7_alt;
						base_ctrl.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
					end
				endcase
			end
			OPC_OP: begin
				base_hit             = f7_base;          // Most ops accept only a zero funct7
				base_ctrl.rs1_access = 1'b1;
				base_ctrl.rs2_access = 1'b1;
				base_ctrl.rd_access  = 1'b1;
				case (f.funct3)
					F3_ADD_SUB: begin
						base_hit         = f7_base || f7_alt;
						base_ctrl.alu_op = f7_alt ? ALU_SUB : ALU_ADD;
					end
					F3_SLL:     base_ctrl.alu_op = ALU_SLL;
					F3_SLT:     base_ctrl.alu_op = ALU_SLT;
					F3_SLTU:    base_ctrl.alu_op = ALU_SLTU;
					F3_XOR:     base_ctrl.alu_op = ALU_XOR;
					F3_OR:      base_ctrl.alu_op = ALU_OR;
					F3_AND:     base_ctrl.alu_op = ALU_AND;
					F3_SRL_SRA: begin
						base_hit         = f7_base || f7_alt;
						base_ctrl.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
					end
				endcase
			end
			OPC_MISC_MEM: base_hit = (f.funct3 == F3_FENCE); // Ordering fields are ignored
			OPC_SYSTEM:   base_hit = (ir == ECALL_WORD) || (ir == EBREAK_WORD);
			default:      base_hit = 1'b0;
		endcase
		if (!base_hit) begin
			base_ctrl = CTRL_NOP;                        // A miss leaves nothing half decoded
			imm_fmt   = IMM_NONE;
		end
		base_ctrl.rs1_addr = f.rs1;                      // Register fields pass through raw
		base_ctrl.rs2_addr = f.rs2;
		base_ctrl.rd_addr  = f.rd;
	end

endmodule

`default_nettype wire

// File: rtl/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Data word width of the core and also the instruction word width
`define XLEN 32

// Register index width for the 32 integer registers
`define REG_ADDR_W 5

// Major opcode occupies the low seven bits of every instruction
`define OPCODE_W 7

// Minor function code widths of the R, I, S and B formats
`define FUNCT3_W 3
`define FUNCT7_W 7

`endif

// File: rtl/decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

	import rv_isa_pkg::*;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,                                 // Also the address adder for loads and stores
		ALU_SUB  = 4'd1,
		ALU_INC  = 4'd2,                                 // PC plus four for the link register
		ALU_SEQ  = 4'd3,
		ALU_SNE  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SGE  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_SGEU = 4'd8,
		ALU_XOR  = 4'd9,
		ALU_OR   = 4'd10,
		ALU_AND  = 4'd11,
		ALU_SLL  = 4'd12,
		ALU_SRL  = 4'd13,
		ALU_SRA  = 4'd14
	} alu_op_e;

	// Nine codes including the idle one need a fourth bit
	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		MEM_LB   = 4'd1,
		MEM_LH   = 4'd2,
		MEM_LW   = 4'd3,
		MEM_LBU  = 4'd4,
		MEM_LHU  = 4'd5,
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} mem_op_e;

	typedef enum logic [1:0] {
		UMULL  = 2'd0,                                   // Low word which is sign agnostic
		SMULH  = 2'd1,
		SUMULH = 2'd2,                                   // Signed rs1 times unsigned rs2
		UMULH  = 2'd3
	} mul_op_e;

	typedef enum logic [1:0] {
		SDIV = 2'd0,
		UDIV = 2'd1,
		SREM = 2'd2,
		UREM = 2'd3
	} div_op_e;

	typedef enum logic [2:0] {
		WB_ALU = 3'd0,
		WB_MEM = 3'd1,
		WB_MUL = 3'd2,
		WB_DIV = 3'd3
	} wb_src_e;

	typedef struct packed {
		reg_addr_t rs1_addr;                             // Raw rs1 field whether read or not
		logic      rs1_access;
		reg_addr_t rs2_addr;                             // Raw rs2 field whether read or not
		logic      rs2_access;
		reg_addr_t rd_addr;                              // Raw rd field whether written or not
		logic      rd_access;
		logic      sel_pc;                               // ALU operand A is the PC instead of rs1
		logic      sel_im;                               // ALU operand B is the immediate
		wb_src_e   wb_src;
		alu_op_e   alu_op;
		mem_op_e   mem_op;
		mul_op_e   mul_op;
		div_op_e   div_op;
		logic      jump_ena;                             // Branch or jump unit takes part
		logic      jump_ind;                             // Target is rs1 plus immediate
		logic      jump_alw;                             // Unconditional transfer
		logic      illegal_inst;
	} decode_ctrl_t;

	localparam decode_ctrl_t CTRL_NOP = '0;              // Every field idle

endpackage

`default_nettype wire

// File: rtl/decode_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg
	import rv_isa_pkg::*;
	import decode_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         ir_valid,
	input  logic         base_hit,
	input  logic         md_hit,
	input  decode_ctrl_t base_ctrl,
	input  decode_ctrl_t md_ctrl,
	input  word_t        imm,
	output logic         id_valid,
	output decode_ctrl_t id_ctrl,
	output word_t        id_imm
);

	decode_ctrl_t ctrl_d;                                // Merged control word before the flops
	word_t        imm_d;

	always_comb begin
		ctrl_d = CTRL_NOP;
		imm_d  = '0;
		if (base_hit) begin
			ctrl_d = base_ctrl;
			imm_d  = imm;
		end else if (md_hit) begin
			ctrl_d = md_ctrl;
			imm_d  = imm;                                // Already zero for R-type words
		end else begin
			ctrl_d.illegal_inst = 1'b1;                  // Neither group claimed the word
			ctrl_d.rs1_addr     = base_ctrl.rs1_addr;    // Both decoders carry the raw fields
			ctrl_d.rs2_addr     = base_ctrl.rs2_addr;
			ctrl_d.rd_addr      = base_ctrl.rd_addr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
			id_ctrl  <= CTRL_NOP;
			id_imm   <= '0;
		end else begin
			id_valid <= ir_valid;                        // Strobe follows the word by one cycle
			if (ir_valid) begin
				id_ctrl <= ctrl_d;                       // Outputs hold across gaps
				id_imm  <= imm_d;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module imm_gen
	import rv_isa_pkg::*;
(
	input  word_t    ir,
	input  imm_fmt_e imm_fmt,
	output word_t    imm
);

	word_t imm_i;                                        // Loads, JALR and ALU immediates
	word_t imm_s;                                        // Stores split the offset around rd
	word_t imm_b;                                        // Branch offsets in halfword units
	word_t imm_u;                                        // Upper twenty bits for LUI and AUIPC
	word_t imm_j;                                        // JAL offsets in halfword units

	// Bit 31 is the sign in every format so the replication always starts there
	assign imm_i = {{(`XLEN-11){ir[31]}}, ir[30:20]};
	assign imm_s = {{(`XLEN-11){ir[31]}}, ir[30:25], ir[11:7]};
	assign imm_b = {{(`XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'h000};
	assign imm_j = {{(`XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

	always_comb begin
		case (imm_fmt)
			IMM_I:   imm = imm_i;
			IMM_S:   imm = imm_s;
			IMM_B:   imm = imm_b;
			IMM_U:   imm = imm_u;
			IMM_J:   imm = imm_j;
			default: imm = '0;                           // Unused format codes also give zero
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
	import rv_isa_pkg::*;
	import decode_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  word_t        ir,
	input  logic         ir_valid,
	output logic         id_valid,
	output decode_ctrl_t id_ctrl,
	output word_t        id_imm
);

	logic         base_hit;                              // RV32I match
	decode_ctrl_t base_ctrl;
	imm_fmt_e     imm_fmt;                               // Format chosen by the base decoder
	word_t        imm;
	logic         md_hit;                                // RV32M match
	decode_ctrl_t md_ctrl;

	base_decoder u_base_decoder (
		.ir        (ir),
		.base_hit  (base_hit),
		.base_ctrl (base_ctrl),
		.imm_fmt   (imm_fmt)
	);

	muldiv_decoder u_muldiv_decoder (
		.ir      (ir),
		.md_hit  (md_hit),
		.md_ctrl (md_ctrl)
	);

	imm_gen u_imm_gen (
		.ir      (ir),
		.imm_fmt (imm_fmt),
		.imm     (imm)
	);

	decode_stage_reg u_decode_stage_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.ir_valid  (ir_valid),
		.base_hit  (base_hit),
		.md_hit    (md_hit),
		.base_ctrl (base_ctrl),
		.md_ctrl   (md_ctrl),
		.imm       (imm),
		.id_valid  (id_valid),
		.id_ctrl   (id_ctrl),
		.id_imm    (id_imm)
	);

endmodule

`default_nettype wire

// File: rtl/muldiv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_decoder
	import rv_isa_pkg::*;
	import decode_ctrl_pkg::*;
(
	input  word_t        ir,
	output logic         md_hit,
	output decode_ctrl_t md_ctrl
);

	inst_fields_t f;

	assign f = inst_fields_t'(ir);

	// Every funct3 value is defined once the opcode and funct7 match
	assign md_hit = (f.opcode == OPC_OP) && (f.funct7 == F7_MULDIV);

	always_comb begin
		md_ctrl          = CTRL_NOP;
		md_ctrl.rs1_addr = f.rs1;                        // Raw fields even on a miss
		md_ctrl.rs2_addr = f.rs2;
		md_ctrl.rd_addr  = f.rd;
		if (md_hit) begin
			md_ctrl.rs1_access = 1'b1;
			md_ctrl.rs2_access = 1'b1;
			md_ctrl.rd_access  = 1'b1;
			// Bit 2 of funct3 splits the group and the low bits follow the enum order
			if (f.funct3[2]) begin
				md_ctrl.wb_src = WB_DIV;                 // DIV DIVU REM REMU
				md_ctrl.div_op = div_op_e'(f.funct3[1:0]);
			end else begin
				md_ctrl.wb_src = WB_MUL;                 // MUL MULH MULHSU MULHU
				md_ctrl.mul_op = mul_op_e'(f.funct3[1:0]);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	`include "decode_cfg.svh"

	typedef logic [`XLEN-1:0] word_t;                    // Instruction or immediate word
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;          // Integer register index

	// Overlay of the R-type layout on a raw word
	// Other formats reuse the same bit positions for their register fields
	typedef struct packed {
		logic [`FUNCT7_W-1:0] funct7;                    // Bits 31 to 25
		reg_addr_t rs2;                                  // Bits 24 to 20
		reg_addr_t rs1;                                  // Bits 19 to 15
		logic [`FUNCT3_W-1:0] funct3;                    // Bits 14 to 12
		reg_addr_t rd;                                   // Bits 11 to 7
		logic [`OPCODE_W-1:0] opcode;                    // Bits 6 to 0
	} inst_fields_t;

	typedef enum logic [`OPCODE_W-1:0] {
		OPC_LUI      = 7'b0110111,
		OPC_AUIPC    = 7'b0010111,
		OPC_JAL      = 7'b1101111,
		OPC_JALR     = 7'b1100111,
		OPC_BRANCH   = 7'b1100011,
		OPC_LOAD     = 7'b0000011,
		OPC_STORE    = 7'b0100011,
		OPC_OP_IMM   = 7'b0010011,
		OPC_OP       = 7'b0110011,
		OPC_MISC_MEM = 7'b0001111,
		OPC_SYSTEM   = 7'b1110011
	} opcode_e;

	localparam logic [`FUNCT7_W-1:0] F7_BASE   = 7'h00;  // Normal ALU and shift encodings
	localparam logic [`FUNCT7_W-1:0] F7_ALT    = 7'h20;  // Selects SUB and SRA
	localparam logic [`FUNCT7_W-1:0] F7_MULDIV = 7'h01;  // Marks the RV32M group

	localparam logic [`FUNCT3_W-1:0] F3_ADD_SUB = 3'd0;  // Integer computational group
	localparam logic [`FUNCT3_W-1:0] F3_SLL     = 3'd1;
	localparam logic [`FUNCT3_W-1:0] F3_SLT     = 3'd2;
	localparam logic [`FUNCT3_W-1:0] F3_SLTU    = 3'd3;
	localparam logic [`FUNCT3_W-1:0] F3_XOR     = 3'd4;
	localparam logic [`FUNCT3_W-1:0] F3_SRL_SRA = 3'd5;
	localparam logic [`FUNCT3_W-1:0] F3_OR      = 3'd6;
	localparam logic [`FUNCT3_W-1:0] F3_AND     = 3'd7;

	localparam logic [`FUNCT3_W-1:0] F3_BEQ  = 3'd0;     // Conditional branch group
	localparam logic [`FUNCT3_W-1:0] F3_BNE  = 3'd1;
	localparam logic [`FUNCT3_W-1:0] F3_BLT  = 3'd4;
	localparam logic [`FUNCT3_W-1:0] F3_BGE  = 3'd5;
	localparam logic [`FUNCT3_W-1:0] F3_BLTU = 3'd6;
	localparam logic [`FUNCT3_W-1:0] F3_BGEU = 3'd7;

	localparam logic [`FUNCT3_W-1:0] F3_B  = 3'd0;       // Access sizes shared by loads and stores
	localparam logic [`FUNCT3_W-1:0] F3_H  = 3'd1;
	localparam logic [`FUNCT3_W-1:0] F3_W  = 3'd2;
	localparam logic [`FUNCT3_W-1:0] F3_BU = 3'd4;       // Zero-extending loads only
	localparam logic [`FUNCT3_W-1:0] F3_HU = 3'd5;

	localparam logic [`FUNCT3_W-1:0] F3_FENCE = 3'd0;    // FENCE.I is not part of RV32I

	localparam word_t ECALL_WORD  = 32'h0000_0073;       // The only legal ECALL encoding
	localparam word_t EBREAK_WORD = 32'h0010_0073;       // The only legal EBREAK encoding

	typedef enum logic [2:0] {
		IMM_NONE = 3'd0,                                 // R-type and no-op words carry no immediate
		IMM_I    = 3'd1,
		IMM_S    = 3'd2,
		IMM_B    = 3'd3,
		IMM_U    = 3'd4,
		IMM_J    = 3'd5
	} imm_fmt_e;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module inst_decoder_tb -f compile.f -o inst_decoder_sim

status=0
./obj_dir/inst_decoder_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	echo "Simulation ended without a pass result"
	exit 1
fi
